/* dv/mr_ddr_model.sv */
// Behavioral DDR memory for the DDR sharing testbench
// Random busy and random gaps between returned read words

module mr_ddr_model
    import mr_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  ddr_req_t          req,
    input  logic              rnd_busy,
    input  logic              rnd_gap,
    output logic              busy,
    output logic [DDR_DW-1:0] dout,
    output logic              dout_ready
);

    logic [DDR_DW-1:0] mem [logic [DDR_AW-1:0]];
    logic [DDR_AW-1:0] rd_q [$];
    logic [DDR_AW-1:0] wr_addr;
    logic [BCNT_W-1:0] wr_len;
    logic [BCNT_W-1:0] wr_beat;

    // Preload pattern, every address bit shows up twice
    function automatic logic [DDR_DW-1:0] fill_word(input logic [DDR_AW-1:0] a);
        return {a, 6'h2d, ~a};
    endfunction

    function automatic logic [DDR_DW-1:0] read_word(input logic [DDR_AW-1:0] a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    always @(posedge clk or negedge rst_n) begin
        logic [DDR_AW-1:0] base;
        logic [BCNT_W-1:0] len;
        if (!rst_n) begin
            busy       <= 1'b0;
            dout       <= '0;
            dout_ready <= 1'b0;
            wr_addr    <= '0;
            wr_len     <= '0;
            wr_beat    <= '0;
            rd_q.delete();
        end else begin
            busy       <= rnd_busy;
            dout_ready <= 1'b0;
            // Whole read burst queued when the request is taken
            if (req.rd && !busy) begin
                for (int i = 0; i < int'(req.burstcnt); i++) begin
                    rd_q.push_back(req.addr + DDR_AW'(i));
                end
            end
            if (rd_q.size() != 0 && !rnd_gap) begin
                dout       <= read_word(rd_q.pop_front());
                dout_ready <= 1'b1;
            end
            // Address and length latched on the first write word
            if (req.we && !busy) begin
                base = (wr_beat == '0) ? req.addr : wr_addr;
                len  = (wr_beat == '0) ? req.burstcnt : wr_len;
                mem[base + DDR_AW'(wr_beat)] = req.din;
                wr_addr <= base;
                wr_len  <= len;
                wr_beat <= (wr_beat + 1'b1 == len) ? '0 : wr_beat + 1'b1;
            end
        end
    end

endmodule

/* dv/mr_tb.sv */
// Testbench for the DDR sharing top level
// ROM downloads under random waits, alone and next to pixel traffic

module mr_tb
    import mr_pkg::*;
();

    localparam int BURST   = 4;
    localparam int TIMEOUT = 20000;
    localparam logic [DDR_AW-1:0] FB_BASE = 29'h4000;

    logic              clk       = 1'b0;
    logic              rst_n;
    logic              dl_start;
    logic [DDR_AW-1:0] dl_base;
    logic [DDR_AW-1:0] dl_len;
    logic [DDR_AW-1:0] fb_base   = FB_BASE;
    logic              rom_wait  = 1'b0;
    logic              pix_valid = 1'b0;
    logic [PIX_W-1:0]  pix_data  = '0;
    logic              rnd_busy  = 1'b0;
    logic              rnd_gap   = 1'b0;
    logic              pix_en    = 1'b0;
    logic              wait_en   = 1'b0;
    logic [31:0]       lfsr      = 32'h449;
    logic              rom_wr;
    logic [ROM_AW-1:0] rom_addr;
    logic [7:0]        rom_data;
    logic              downloading;
    logic              pix_ready;
    logic              ddr_busy;
    logic [DDR_DW-1:0] ddr_dout;
    logic              ddr_dout_ready;
    ddr_req_t          ddr_req;

    // Scoreboards
    logic [DDR_AW-1:0] ld_base     = '0;
    int                nbytes      = 0;
    int                fb_words    = 0;
    int                rd_pending  = 0;
    logic [PIX_W-1:0]  pix_q [$];
    int                errors_ld   = 0;
    int                errors_fb   = 0;
    int                errors_prop = 0;
    int                errors_seq  = 0;
    int                timeouts    = 0;

    always #2 clk = ~clk;

    mr_ddr_top #(.BURST(BURST)) DUT (
        .clk_rom        ( clk            ),
        .rst_n          ( rst_n          ),
        .dl_start       ( dl_start       ),
        .dl_base        ( dl_base        ),
        .dl_len         ( dl_len         ),
        .rom_wait       ( rom_wait       ),
        .rom_wr         ( rom_wr         ),
        .rom_addr       ( rom_addr       ),
        .rom_data       ( rom_data       ),
        .downloading    ( downloading    ),
        .pix_valid      ( pix_valid      ),
        .pix_data       ( pix_data       ),
        .fb_base        ( fb_base        ),
        .pix_ready      ( pix_ready      ),
        .ddr_busy       ( ddr_busy       ),
        .ddr_dout       ( ddr_dout       ),
        .ddr_dout_ready ( ddr_dout_ready ),
        .ddr_req        ( ddr_req        )
    );

    mr_ddr_model u_mem (
        .clk        ( clk            ),
        .rst_n      ( rst_n          ),
        .req        ( ddr_req        ),
        .rnd_busy   ( rnd_busy       ),
        .rnd_gap    ( rnd_gap        ),
        .busy       ( ddr_busy       ),
        .dout       ( ddr_dout       ),
        .dout_ready ( ddr_dout_ready )
    );

    // Galois LFSR, one step per bit
    function automatic logic take_bit();
        logic out;
        out  = lfsr[0];
        lfsr = lfsr >> 1;
        if (out) begin
            lfsr = lfsr ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [PIX_W-1:0] take_pixel();
        logic [PIX_W-1:0] v;
        for (int i = 0; i < PIX_W; i++) begin
            v[i] = take_bit();
        end
        return v;
    endfunction

    // Memory contents before any write
    function automatic logic [DDR_DW-1:0] expected_word(input logic [DDR_AW-1:0] a);
        return {a, 6'h2d, ~a};
    endfunction

    function automatic void print_mismatch(input string name, input logic [DDR_DW-1:0] exp,
                                           input logic [DDR_DW-1:0] act);
        $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
    endfunction

    always @(posedge clk) begin
        rnd_busy  <= take_bit() & take_bit();
        rnd_gap   <= take_bit();
        rom_wait  <= wait_en & take_bit() & take_bit();
        pix_valid <= pix_en & take_bit();
        pix_data  <= take_pixel();
    end

    // ROM byte stream against memory contents
    always @(posedge clk) begin
        logic [DDR_DW-1:0] word;
        if (dl_start) begin
            ld_base <= dl_base;
            nbytes  <= 0;
        end
        if (rom_wr) begin
            word = expected_word(ld_base + DDR_AW'(nbytes / BYTES_PER_WORD));
            assert (rom_addr == ROM_AW'(nbytes)) else begin
                errors_ld++;
                print_mismatch("download rom_addr", nbytes, rom_addr);
            end
            assert (rom_data == word[nbytes % BYTES_PER_WORD * 8 +: 8]) else begin
                errors_ld++;
                print_mismatch("download rom_data", word[nbytes % BYTES_PER_WORD * 8 +: 8],
                               rom_data);
            end
            nbytes <= nbytes + 1;
        end
    end

    // Write words against accepted pixels, and read words still due
    always @(posedge clk) begin
        logic [DDR_DW-1:0] din;
        if (pix_valid && pix_ready) begin
            pix_q.push_back(pix_data);
        end
        rd_pending <= rd_pending + ((ddr_req.rd && !ddr_busy) ? int'(ddr_req.burstcnt) : 0)
                      - (ddr_dout_ready ? 1 : 0);
        if (ddr_req.rd && !ddr_busy) begin
            assert (ddr_req.burstcnt == BCNT_W'(BURST)) else begin
                errors_ld++;
                print_mismatch("read burst length", BURST, ddr_req.burstcnt);
            end
        end
        if (ddr_req.we && !ddr_busy) begin
            assert (rd_pending == 0) else begin
                errors_fb++;
                $display("Write word accepted while %0d read words were still due", rd_pending);
            end
            if (fb_words % BURST == 0) begin
                assert (ddr_req.addr == FB_BASE + DDR_AW'(fb_words)) else begin
                    errors_fb++;
                    print_mismatch("frame burst address", FB_BASE + DDR_AW'(fb_words),
                                   ddr_req.addr);
                end
                assert (ddr_req.burstcnt == BCNT_W'(BURST)) else begin
                    errors_fb++;
                    print_mismatch("frame burst length", BURST, ddr_req.burstcnt);
                end
            end
            assert (ddr_req.be == 8'hff) else begin
                errors_fb++;
                print_mismatch("frame byte enables", 8'hff, ddr_req.be);
            end
            din = '0;
            for (int i = 0; i < PIX_PER_WORD; i++) begin
                if (pix_q.size() != 0) begin
                    din[i*PIX_W +: PIX_W] = pix_q.pop_front();
                end
            end
            assert (ddr_req.din == din) else begin
                errors_fb++;
                print_mismatch("frame word data", din, ddr_req.din);
            end
            fb_words <= fb_words + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) rom_wait |-> !rom_wr)
        else begin
            errors_prop++;
            $display("ROM byte written while rom_wait was high");
        end
    assert property (@(posedge clk) disable iff (!rst_n) rom_wr |-> downloading)
        else begin
            errors_prop++;
            $display("ROM byte written outside a download");
        end
    assert property (@(posedge clk) disable iff (!rst_n) dl_start |=> downloading)
        else begin
            errors_prop++;
            $display("downloading did not rise on the cycle after dl_start");
        end
    assert property (@(posedge clk) disable iff (!rst_n) !(ddr_req.rd && ddr_req.we))
        else begin
            errors_prop++;
            $display("Read and write both driven on the DDR port");
        end

    task automatic check_value(input string name, input logic [DDR_DW-1:0] exp,
                               input logic [DDR_DW-1:0] act);
        assert (exp == act) else begin
            errors_seq++;
            print_mismatch(name, exp, act);
        end
    endtask

    task automatic wait_downloading(input logic level);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (downloading !== level && t < TIMEOUT);
        if (downloading !== level) begin
            timeouts++;
            $display("Timed out waiting for downloading to go %0b", level);
        end
    endtask

    task automatic wait_bursts(input int n);
        int t;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (fb_words < n * BURST && t < TIMEOUT);
        if (fb_words < n * BURST) begin
            timeouts++;
            $display("Timed out waiting for %0d frame-buffer bursts", n);
        end
    endtask

    task automatic run_download(input logic [DDR_AW-1:0] base, input int words);
        @(posedge clk);
        dl_base  <= base;
        dl_len   <= DDR_AW'(words);
        dl_start <= 1'b1;
        @(posedge clk);
        dl_start <= 1'b0;
        wait_downloading(1'b1);
        wait_downloading(1'b0);
        check_value("download byte count", words * BYTES_PER_WORD, nbytes);
    endtask

    initial begin
        rst_n    = 1'b0;
        dl_start = 1'b0;
        dl_base  = '0;
        dl_len   = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("reset rom_wr", 0, rom_wr);
        check_value("reset downloading", 0, downloading);
        check_value("reset ddr rd", 0, ddr_req.rd);
        check_value("reset ddr we", 0, ddr_req.we);
        check_value("reset pix_ready", 1, pix_ready);
        // Download alone under ROM waits
        wait_en <= 1'b1;
        run_download(29'h100, 4 * BURST);
        // Pixel traffic, then a longer download running alongside it
        pix_en <= 1'b1;
        wait_bursts(3);
        run_download(29'h1_2345, 8 * BURST);
        wait_bursts(fb_words / BURST + 2);
        pix_en <= 1'b0;
        @(negedge clk);
        $display("Errors: download %0d, frame %0d, properties %0d, sequence %0d, timeouts %0d",
                 errors_ld, errors_fb, errors_prop, errors_seq, timeouts);
        if (errors_ld + errors_fb + errors_prop + errors_seq + timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
hw/mr_pkg.sv
hw/mr_ddr_loader.sv
hw/mr_fb_writer.sv
hw/mr_ddr_arbiter.sv
hw/mr_ddr_top.sv
dv/mr_ddr_model.sv
dv/mr_tb.sv

/* hw/mr_ddr_arbiter.sv */
// DDR port arbiter
// Grants the shared port to the loader or the frame-buffer writer and
// keeps the grant until the burst has fully completed

module mr_ddr_arbiter
    import mr_pkg::*;
#(
    parameter int BURST = 4
) (
    input  logic     clk_rom,
    input  logic     rst_n,
    input  logic     downloading,
    // Clients
    input  ddr_req_t ld_req,
    input  ddr_req_t fb_req,
    output logic     ld_busy,
    output logic     fb_busy,
    // External port
    input  logic     ddr_busy,
    input  logic     ddr_dout_ready,
    output ddr_req_t ddr_req
);

    localparam int CNT_W = $clog2(BURST);

    arb_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic             beat;
    logic             burst_end;
    logic             ld_win;

    // Loader has priority during a download
    assign ld_win = ld_req.rd && (downloading || !fb_req.we);

    // Read beats come back, write beats go out
    always_comb begin
        case (state)
            ARB_LOAD: beat = ddr_dout_ready;
            ARB_FB:   beat = ddr_req.we && !ddr_busy;
            default:  beat = 1'b0;
        endcase
    end

    assign burst_end = beat && cnt == CNT_W'(BURST - 1);

    // Port mux, the idle client sees a busy port
    always_comb begin
        ddr_req = '0;
        ld_busy = 1'b1;
        fb_busy = 1'b1;
        case (state)
            ARB_LOAD: begin
                ddr_req = ld_req;
                ld_busy = ddr_busy;
            end
            ARB_FB: begin
                ddr_req = fb_req;
                fb_busy = ddr_busy;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    cnt <= '0;
                    if (ld_win) begin
                        state <= ARB_LOAD;
                    end else if (fb_req.we) begin
                        state <= ARB_FB;
                    end
                end
                ARB_LOAD, ARB_FB: begin
                    if (beat) begin
                        cnt <= cnt + 1'b1;
                    end
                    if (burst_end) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assert property (@(posedge clk_rom) disable iff (!rst_n)
        !(ddr_req.rd && ddr_req.we));

    // Grant only drops back to idle at a burst boundary
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        (state != ARB_IDLE && !burst_end) |=> state == $past(state));

endmodule

/* hw/mr_ddr_loader.sv */
// DDR fast-load engine
// Reads one burst at a time into a word buffer, then serializes the
// buffer as ROM bytes, least significant byte of each word first

module mr_ddr_loader
    import mr_pkg::*;
#(
    parameter int BURST = 4
) (
    input  logic              clk_rom,
    input  logic              rst_n,
    // Download control
    input  logic              dl_start,
    input  logic [DDR_AW-1:0] dl_base,
    input  logic [DDR_AW-1:0] dl_len,
    // DDR side
    input  logic              busy,
    input  logic [DDR_DW-1:0] dout,
    input  logic              dout_ready,
    output ddr_req_t          req,
    // ROM programming stream
    input  logic              rom_wait,
    output logic              rom_wr,
    output logic [ROM_AW-1:0] rom_addr,
    output logic [7:0]        rom_data,
    output logic              downloading
);

    localparam int NBYTES = BURST * BYTES_PER_WORD;
    localparam int WIDX_W = $clog2(BURST);
    localparam int BIDX_W = $clog2(NBYTES);
    localparam int SEL_W  = $clog2(BYTES_PER_WORD);

    ld_state_e         state;
    logic [DDR_AW-1:0] rd_addr;
    logic [DDR_AW-1:0] wleft;
    logic [WIDX_W-1:0] fcnt;
    logic [BIDX_W-1:0] bidx;
    logic [DDR_DW-1:0] wbuf [BURST];
    logic [DDR_DW-1:0] cur_word;
    logic              last_fill;
    logic              last_byte;

    assign last_fill = dout_ready && fcnt == WIDX_W'(BURST - 1);
    assign last_byte = bidx == BIDX_W'(NBYTES - 1);

    // Byte select inside the buffer
    assign cur_word = wbuf[bidx[BIDX_W-1:SEL_W]];
    assign rom_data = cur_word[bidx[SEL_W-1:0]*8 +: 8];
    assign rom_wr   = state == LD_DRAIN && !rom_wait;

    always_comb begin
        req          = '0;
        req.rd       = state == LD_REQ;
        req.addr     = rd_addr;
        req.burstcnt = BCNT_W'(BURST);
        req.be       = '1;
    end

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            state       <= LD_IDLE;
            downloading <= 1'b0;
            rd_addr     <= '0;
            wleft       <= '0;
            fcnt        <= '0;
            bidx        <= '0;
            rom_addr    <= '0;
        end else begin
            case (state)
                LD_IDLE: begin
                    if (dl_start) begin
                        state       <= LD_REQ;
                        downloading <= 1'b1;
                        rd_addr     <= dl_base;
                        wleft       <= dl_len;
                        rom_addr    <= '0;
                    end
                end
                LD_REQ: begin
                    // Read accepted, move on to the next burst address
                    if (!busy) begin
                        state   <= LD_FILL;
                        fcnt    <= '0;
                        rd_addr <= rd_addr + DDR_AW'(BURST);
                        wleft   <= wleft - DDR_AW'(BURST);
                    end
                end
                LD_FILL: begin
                    if (dout_ready) begin
                        fcnt <= fcnt + 1'b1;
                        if (last_fill) begin
                            state <= LD_DRAIN;
                            bidx  <= '0;
                        end
                    end
                end
                LD_DRAIN: begin
                    if (rom_wr) begin
                        bidx     <= bidx + 1'b1;
                        rom_addr <= rom_addr + 1'b1;
                        if (last_byte) begin
                            if (wleft == '0) begin
                                state       <= LD_IDLE;
                                downloading <= 1'b0;
                            end else begin
                                state <= LD_REQ;
                            end
                        end
                    end
                end
                default: state <= LD_IDLE;
            endcase
        end
    end

    // Returned words land in order
    always_ff @(posedge clk_rom) begin
        if (state == LD_FILL && dout_ready) begin
            wbuf[fcnt] <= dout;
        end
    end

    // No byte while the ROM side waits or outside a download
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        rom_wr |-> (downloading && !rom_wait));

    // Read request held until the port takes it
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        (req.rd && busy) |=> (req.rd && $stable(req.addr)));

endmodule

/* hw/mr_ddr_top.sv */
// DDR sharing top level
// Fast-load engine and frame-buffer writer behind one DDR port arbiter

module mr_ddr_top
    import mr_pkg::*;
#(
    parameter int BURST = 4
) (
    input  logic              clk_rom,
    input  logic              rst_n,
    // Download
    input  logic              dl_start,
    input  logic [DDR_AW-1:0] dl_base,
    input  logic [DDR_AW-1:0] dl_len,
    input  logic              rom_wait,
    output logic              rom_wr,
    output logic [ROM_AW-1:0] rom_addr,
    output logic [7:0]        rom_data,
    output logic              downloading,
    // Pixels
    input  logic              pix_valid,
    input  logic [PIX_W-1:0]  pix_data,
    input  logic [DDR_AW-1:0] fb_base,
    output logic              pix_ready,
    // DDR port
    input  logic              ddr_busy,
    input  logic [DDR_DW-1:0] ddr_dout,
    input  logic              ddr_dout_ready,
    output ddr_req_t          ddr_req
);

    ddr_req_t ld_req;
    ddr_req_t fb_req;
    logic     ld_busy;
    logic     fb_busy;

    mr_ddr_loader #(.BURST(BURST)) u_loader (
        .clk_rom     ( clk_rom        ),
        .rst_n       ( rst_n          ),
        .dl_start    ( dl_start       ),
        .dl_base     ( dl_base        ),
        .dl_len      ( dl_len         ),
        .busy        ( ld_busy        ),
        .dout        ( ddr_dout       ),
        .dout_ready  ( ddr_dout_ready ),
        .req         ( ld_req         ),
        .rom_wait    ( rom_wait       ),
        .rom_wr      ( rom_wr         ),
        .rom_addr    ( rom_addr       ),
        .rom_data    ( rom_data       ),
        .downloading ( downloading    )
    );

    mr_fb_writer #(.BURST(BURST)) u_fb (
        .clk_rom     ( clk_rom        ),
        .rst_n       ( rst_n          ),
        .pix_valid   ( pix_valid      ),
        .pix_data    ( pix_data       ),
        .pix_ready   ( pix_ready      ),
        .fb_base     ( fb_base        ),
        .busy        ( fb_busy        ),
        .req         ( fb_req         )
    );

    mr_ddr_arbiter #(.BURST(BURST)) u_arb (
        .clk_rom        ( clk_rom        ),
        .rst_n          ( rst_n          ),
        .downloading    ( downloading    ),
        .ld_req         ( ld_req         ),
        .fb_req         ( fb_req         ),
        .ld_busy        ( ld_busy        ),
        .fb_busy        ( fb_busy        ),
        .ddr_busy       ( ddr_busy       ),
        .ddr_dout_ready ( ddr_dout_ready ),
        .ddr_req        ( ddr_req        )
    );

endmodule

/* hw/mr_fb_writer.sv */
// Frame-buffer writer
// Packs four pixels per DDR word into a line buffer and writes the
// buffer to consecutive burst slots above fb_base

module mr_fb_writer
    import mr_pkg::*;
#(
    parameter int BURST = 4
) (
    input  logic              clk_rom,
    input  logic              rst_n,
    // Pixel stream
    input  logic              pix_valid,
    input  logic [PIX_W-1:0]  pix_data,
    output logic              pix_ready,
    // DDR side
    input  logic [DDR_AW-1:0] fb_base,
    input  logic              busy,
    output ddr_req_t          req
);

    localparam int NPIX   = BURST * PIX_PER_WORD;
    localparam int WIDX_W = $clog2(BURST);
    localparam int PIDX_W = $clog2(NPIX);
    localparam int PSEL_W = $clog2(PIX_PER_WORD);

    fb_state_e         state;
    logic [PIDX_W-1:0] pcnt;
    logic [WIDX_W-1:0] wcnt;
    logic [DDR_AW-1:0] nburst;
    logic [DDR_DW-1:0] lbuf [BURST];
    logic              pix_take;
    logic              wr_take;
    logic              wr_last;

    assign pix_ready = state == FB_FILL;
    assign pix_take  = pix_valid && pix_ready;
    assign wr_take   = req.we && !busy;
    assign wr_last   = wr_take && wcnt == WIDX_W'(BURST - 1);

    always_comb begin
        req          = '0;
        req.we       = state == FB_WRITE;
        req.addr     = fb_base + DDR_AW'(nburst * BURST);
        req.burstcnt = BCNT_W'(BURST);
        req.be       = '1;
        req.din      = lbuf[wcnt];
    end

    always_ff @(posedge clk_rom or negedge rst_n) begin
        if (!rst_n) begin
            state  <= FB_FILL;
            pcnt   <= '0;
            wcnt   <= '0;
            nburst <= '0;
        end else begin
            case (state)
                FB_FILL: begin
                    if (pix_take) begin
                        pcnt <= pcnt + 1'b1;
                        // Buffer full, hand it to the DDR
                        if (pcnt == PIDX_W'(NPIX - 1)) begin
                            state <= FB_WRITE;
                            wcnt  <= '0;
                        end
                    end
                end
                FB_WRITE: begin
                    if (wr_take) begin
                        wcnt <= wcnt + 1'b1;
                    end
                    if (wr_last) begin
                        state  <= FB_FILL;
                        nburst <= nburst + 1'b1;
                    end
                end
                default: state <= FB_FILL;
            endcase
        end
    end

    // Earliest pixel in the low lane
    always_ff @(posedge clk_rom) begin
        if (pix_take) begin
            lbuf[pcnt[PIDX_W-1:PSEL_W]][pcnt[PSEL_W-1:0]*PIX_W +: PIX_W] <= pix_data;
        end
    end

    // Write strobe covers the whole burst without a gap
    assert property (@(posedge clk_rom) disable iff (!rst_n)
        (req.we && !wr_last) |=> req.we);

endmodule

/* hw/mr_pkg.sv */
// Shared definitions for the DDR fast-load and frame-buffer path
// Bus widths, the DDR request bundle and the FSM state encodings

package mr_pkg;

    // DDR port geometry
    localparam int DDR_AW         = 29;
    localparam int DDR_DW         = 64;
    localparam int BCNT_W         = 8;

    // ROM programming stream
    localparam int BYTES_PER_WORD = DDR_DW / 8;
    localparam int ROM_AW         = 27;

    // Pixel packing into DDR words
    localparam int PIX_W          = 16;
    localparam int PIX_PER_WORD   = DDR_DW / PIX_W;

    // One requester's view of the DDR port
    typedef struct packed {
        logic              rd;
        logic              we;
        logic [DDR_AW-1:0] addr;
        logic [BCNT_W-1:0] burstcnt;
        logic [7:0]        be;
        logic [DDR_DW-1:0] din;
    } ddr_req_t;

    // Arbiter grant
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_LOAD,
        ARB_FB
    } arb_state_e;

    // Fast-load engine
    typedef enum logic [1:0] {
        LD_IDLE,
        LD_REQ,
        LD_FILL,
        LD_DRAIN
    } ld_state_e;

    // Frame-buffer writer
    typedef enum logic {
        FB_FILL,
        FB_WRITE
    } fb_state_e;

endpackage

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mr_tb -f filelist.f \
    && ./obj_dir/Vmr_tb | tee sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
